// ==== sdram.f ====
+incdir+verilog
verilog/sdram_pkg.sv
verilog/sdram_cmd_decode.sv
verilog/sdram_burst_exec.sv
verilog/sdram_bank_array.sv
verilog/sdram_read_pipe.sv
verilog/sdram.sv
testbench/sdram_asserts.sv
testbench/sdram_checker.sv
testbench/sdram_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= sdram_tb
FILELIST  ?= sdram.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal
SIM_ARGS  ?= +verilator+error+limit+1000

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR) -o sim_$(TOP)
	./$(OBJ_DIR)/sim_$(TOP) $(SIM_ARGS) 2>&1 | tee $(LOG)
	@if grep -q '>>> FAIL' $(LOG); then echo "simulation failed"; exit 1; fi
	@grep -q '>>> PASS' $(LOG) || { echo "simulation ended without a result"; exit 1; }

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== testbench/sdram_tb.sv ====
`timescale 1ns/100ps
`include "sdram_macros.svh"

module sdram_tb;

  localparam int N_RAND = 400;
  localparam int MAX_BL = 8;
  // reset, fill, sweep and random ops, then drain and margin
  localparam int LIMIT = 8 + 16 * (2 + 32) + 8 * (4 + MAX_BL + 3) + N_RAND * MAX_BL
                         + 16 + 8 * MAX_BL;

  logic             clk = 1'b0;
  logic             reset;
  logic             cke;
  logic             cs;
  logic             ras;
  logic             cas;
  logic             we;
  sdram_pkg::addr_t a;
  sdram_pkg::bank_t ba;
  sdram_pkg::mask_t dqm;
  sdram_pkg::data_t dq_in;
  sdram_pkg::data_t dq_out;
  logic             dq_oe;
  sdram_pkg::data_t dq_bus;
  int               phase;
  int               cyc = 0;
  logic [31:0]      rng;
  int               cur_bl;
  int               cur_cl;
  int               busy_until; // edge of the last pending read word
  logic             mask_en;
  int               data_errs;
  int               oe_errs;
  int               total;

  assign dq_bus = dq_oe ? dq_out : dq_in; // device drives the bus only with dq_oe

  sdram u_sdram (
    .clk    (clk),
    .reset  (reset),
    .cke    (cke),
    .cs     (cs),
    .ras    (ras),
    .cas    (cas),
    .we     (we),
    .a      (a),
    .ba     (ba),
    .dqm    (dqm),
    .dq_in  (dq_in),
    .dq_out (dq_out),
    .dq_oe  (dq_oe)
  );

  sdram_checker u_checker (
    .clk       (clk),
    .reset     (reset),
    .cke       (cke),
    .cs        (cs),
    .ras       (ras),
    .cas       (cas),
    .we        (we),
    .a         (a),
    .ba        (ba),
    .dqm       (dqm),
    .dq_in     (dq_in),
    .dq        (dq_bus),
    .dq_oe     (dq_oe),
    .phase     (phase),
    .data_errs (data_errs),
    .oe_errs   (oe_errs)
  );

  always #5 clk = ~clk;

  always @(posedge clk) begin
    cyc = cyc + 1;
    if (cyc > LIMIT) begin
      $display("timeout: stimulus still running after %0d cycles", LIMIT);
      $display(">>> FAIL");
      $finish;
    end
  end

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  function automatic int words(input logic [2:0] code);
    if (code > 3'd3) return 8;
    return 1 << code;
  endfunction

  task automatic drive(input logic [2:0] rcw, input sdram_pkg::addr_t addr,
                       input sdram_pkg::bank_t bank, input logic sel);
    @(negedge clk);
    rng = xorshift32(rng);
    cke = 1'b1;
    cs = !sel;
    {ras, cas, we} = rcw;
    a = addr;
    ba = bank;
    dq_in = rng[15:0]; // write data whenever a burst takes it
    dqm = mask_en ? rng[17:16] : 2'b00;
  endtask

  task automatic idle_cycle();
    logic [1:0] kind;
    kind = rng[20:19];
    case (kind)
      2'd0: begin
        drive(3'b011, rng[12:0], rng[22:21], 1'b1);
        cke = 1'b0; // activate pattern under cke low does nothing
      end
      2'd1:    drive(3'b101, rng[12:0], rng[22:21], 1'b0);
      2'd2:    drive(3'b010, rng[12:0], rng[22:21], 1'b1); // precharge
      default: drive(3'b111, rng[12:0], rng[22:21], 1'b1);
    endcase
  endtask

  task automatic mode_set(input logic [2:0] code, input logic [2:0] lat);
    drive(3'b000, sdram_pkg::addr_t'({lat, 1'b0, code}), 2'd0, 1'b1);
    cur_bl = words(code);
    cur_cl = (lat == 3'd2) ? 2 : 3;
  endtask

  task automatic issue_read(input sdram_pkg::bank_t bank, input sdram_pkg::col_t col);
    drive(3'b101, sdram_pkg::addr_t'(col), bank, 1'b1);
    busy_until = cyc + cur_cl + cur_bl;
  endtask

  task automatic wait_idle();
    while (cyc + 1 <= busy_until) idle_cycle();
  endtask

  task automatic gap(input int k);
    repeat (k) idle_cycle();
  endtask

  initial begin
    reset = 1'b1;
    cke = 1'b0;
    cs = 1'b1;
    {ras, cas, we} = 3'b111;
    a = '0;
    ba = '0;
    dqm = '0;
    dq_in = '0;
    rng = 32'h20de;
    phase = 0;
    mask_en = 1'b0;
    cur_bl = 1;
    cur_cl = 2;
    busy_until = 0;
    repeat (8) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;

    // every column of rows 0 to 3 in every bank with the burst length set by the row
    phase = 1;
    for (int b = 0; b < 4; b++) begin
      for (int r = 0; r < 4; r++) begin
        mode_set(3'(r), (b % 2 == 1) ? 3'd3 : 3'd2);
        drive(3'b011, sdram_pkg::addr_t'(r), 2'(b), 1'b1);
        for (int c = 0; c < 32; c += cur_bl) begin
          drive(3'b100, sdram_pkg::addr_t'(c), 2'(b), 1'b1);
          gap(cur_bl - 1);
        end
      end
    end

    // each burst length under each latency with a start column that wraps longer bursts
    phase = 2;
    for (int code = 0; code < 4; code++) begin
      for (int lat = 2; lat < 4; lat++) begin
        wait_idle();
        mode_set(3'(code), 3'(lat));
        issue_read(2'(code), 5'(32 - code));
        gap(cur_bl - 1);
      end
    end

    phase = 3;
    mask_en = 1'b1;
    for (int i = 0; i < N_RAND; i++) begin
      rng = xorshift32(rng);
      case (rng[3:0])
        4'd0: begin
          if (cyc + 1 > busy_until) mode_set(rng[6:4], rng[10:8]);
          else idle_cycle();
        end
        4'd1, 4'd2: drive(3'b011, sdram_pkg::addr_t'({rng[24:16], 2'b00, rng[5:4]}),
                          rng[7:6], 1'b1);
        4'd3, 4'd4, 4'd5, 4'd6: begin
          issue_read(rng[5:4], rng[10:6]);
          gap(rng[11] ? cur_bl - 1 : int'(rng[14:12]) % cur_bl);
        end
        4'd7, 4'd8, 4'd9, 4'd10: begin
          if (cyc + 1 > busy_until) begin
            drive(3'b100, sdram_pkg::addr_t'(rng[10:6]), rng[5:4], 1'b1);
            gap(rng[11] ? cur_bl - 1 : int'(rng[14:12]) % cur_bl);
          end else begin
            idle_cycle();
          end
        end
        4'd11:   drive(3'b110, '0, '0, 1'b1); // burst terminate
        default: idle_cycle();
      endcase
    end

    wait_idle();
    gap(4);
    total = data_errs + oe_errs + u_sdram.u_asserts.fails;
    $display("errors: data %0d, dq_oe %0d, assertions %0d", data_errs, oe_errs,
             u_sdram.u_asserts.fails);
    if (total == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

endmodule

// ==== testbench/sdram_checker.sv ====
`timescale 1ns/100ps
`include "sdram_macros.svh"

module sdram_checker (
  input  logic             clk,
  input  logic             reset,
  input  logic             cke,
  input  logic             cs,
  input  logic             ras,
  input  logic             cas,
  input  logic             we,
  input  sdram_pkg::addr_t a,
  input  sdram_pkg::bank_t ba,
  input  sdram_pkg::mask_t dqm,
  input  sdram_pkg::data_t dq_in,
  input  sdram_pkg::data_t dq,
  input  logic             dq_oe,
  input  int               phase,
  output int               data_errs,
  output int               oe_errs
);

  localparam int ROWS = 1 << `SDRAM_ROW_BITS;
  localparam int COLS = 1 << `SDRAM_COL_BITS;

  sdram_pkg::data_t mem [4][ROWS][COLS];
  logic [1:0]       known [4][ROWS][COLS]; // bytes written so far
  logic             exp_v [16];
  sdram_pkg::data_t exp_d [16];
  sdram_pkg::data_t exp_k [16];
  sdram_pkg::row_t  open_row [4];
  int               n;
  int               bl;
  int               cl;
  int               b_mode; // 0 idle, 1 read, 2 write
  int               b_cnt;
  int               b_len;
  sdram_pkg::bank_t b_bank;
  sdram_pkg::row_t  b_row;
  sdram_pkg::col_t  b_col;

  initial begin
    foreach (known[i, j, k]) known[i][j][k] = 2'b00;
  end

  function automatic string phase_name(input int p);
    case (p)
      1:       return "fill";
      2:       return "burst_sweep";
      3:       return "random";
      default: return "reset";
    endcase
  endfunction

  function automatic int words(input logic [2:0] code);
    if (code > 3'd3) return 8;
    return 1 << code;
  endfunction

  task automatic read_word(input sdram_pkg::bank_t b, input sdram_pkg::row_t r,
                           input sdram_pkg::col_t c);
    int s;
    s = (n + cl) % 16;
    exp_v[s] = 1'b1;
    exp_d[s] = mem[b][r][c];
    exp_k[s] = {{8{known[b][r][c][1]}}, {8{known[b][r][c][0]}}};
  endtask

  task automatic write_word(input sdram_pkg::bank_t b, input sdram_pkg::row_t r,
                            input sdram_pkg::col_t c);
    if (!dqm[1]) begin
      mem[b][r][c][15:8] = dq_in[15:8];
      known[b][r][c][1] = 1'b1;
    end
    if (!dqm[0]) begin
      mem[b][r][c][7:0] = dq_in[7:0];
      known[b][r][c][0] = 1'b1;
    end
  endtask

  always @(posedge clk) begin
    int s;
    sdram_pkg::cmd_e c;
    sdram_pkg::col_t col;
    if (reset) begin
      n = 0;
      bl = 1;
      cl = 2;
      b_mode = 0;
      data_errs = 0;
      oe_errs = 0;
      for (int i = 0; i < 16; i++) exp_v[i] = 1'b0;
      for (int i = 0; i < 4; i++) open_row[i] = '0;
    end else begin
      n++;
      s = n % 16;
      if (exp_v[s] && !dq_oe) begin
        oe_errs++;
        $display("missing read word: dq_oe low at edge %0d in %s", n, phase_name(phase));
      end else if (!exp_v[s] && dq_oe) begin
        oe_errs++;
        $display("unexpected read word: dq_oe high at edge %0d in %s", n, phase_name(phase));
      end else if (exp_v[s] && (((dq ^ exp_d[s]) & exp_k[s]) != 0)) begin
        data_errs++;
        $display("ERR %s: expected %h actual %h (byte mask %h)", phase_name(phase),
                 exp_d[s] & exp_k[s], dq, exp_k[s]);
      end
      exp_v[s] = 1'b0;
      // standard command truth table
      c = sdram_pkg::cmd_nop;
      if (cke && !cs) begin
        case ({ras, cas, we})
          3'b000:  c = sdram_pkg::cmd_mode;
          3'b011:  c = sdram_pkg::cmd_active;
          3'b101:  c = sdram_pkg::cmd_read;
          3'b100:  c = sdram_pkg::cmd_write;
          3'b110:  c = sdram_pkg::cmd_stop;
          default: c = sdram_pkg::cmd_nop;
        endcase
      end
      if (c == sdram_pkg::cmd_read || c == sdram_pkg::cmd_write || c == sdram_pkg::cmd_stop) begin
        b_mode = 0; // interrupted burst
      end else if (b_mode != 0) begin
        col = sdram_pkg::col_t'(b_col + b_cnt);
        if (b_mode == 1) read_word(b_bank, b_row, col);
        else write_word(b_bank, b_row, col);
        b_cnt++;
        if (b_cnt == b_len) b_mode = 0;
      end
      col = a[`SDRAM_COL_BITS-1:0];
      case (c)
        sdram_pkg::cmd_mode: begin
          bl = words(a[2:0]);
          cl = (a[6:4] == 3'd2) ? 2 : 3;
        end
        sdram_pkg::cmd_active: open_row[ba] = a[`SDRAM_ROW_BITS-1:0];
        sdram_pkg::cmd_read, sdram_pkg::cmd_write: begin
          if (c == sdram_pkg::cmd_read) read_word(ba, open_row[ba], col);
          else write_word(ba, open_row[ba], col);
          if (bl > 1) begin
            b_mode = (c == sdram_pkg::cmd_read) ? 1 : 2;
            b_cnt = 1;
            b_len = bl;
            b_bank = ba;
            b_row = open_row[ba];
            b_col = col;
          end
        end
        default: ;
      endcase
    end
  end

endmodule

// ==== testbench/sdram_asserts.sv ====
`timescale 1ns/100ps

module sdram_asserts (
  input logic              clk,
  input logic              reset,
  input logic              dq_oe,
  input logic              wr_en,
  input logic              rd_valid,
  input sdram_pkg::burst_e state,
  input logic [3:0]        cnt,
  input logic [3:0]        len
);

  int fails = 0; // read by the testbench for its closing line

  a_oe_after_reset: assert property (@(posedge clk) reset |=> !dq_oe)
    else begin
      $error("dq_oe high in the cycle after reset");
      fails++;
    end

  // a write burst never overlaps read data on the bus
  a_no_read_in_write: assert property (@(posedge clk) disable iff (reset)
    (state == sdram_pkg::burst_write && wr_en) |-> (!dq_oe && !rd_valid))
    else begin
      $error("read word due during a write burst");
      fails++;
    end

  a_cnt_below_len: assert property (@(posedge clk) disable iff (reset)
    (state != sdram_pkg::burst_idle) |-> (cnt < len))
    else begin
      $error("burst word counter reached the burst length");
      fails++;
    end

endmodule

bind sdram sdram_asserts u_asserts (
  .clk      (clk),
  .reset    (reset),
  .dq_oe    (dq_oe),
  .wr_en    (wr_en),
  .rd_valid (rd_valid),
  .state    (u_exec.state_r),
  .cnt      (u_exec.cnt_r),
  .len      (u_exec.len_r)
);

// ==== verilog/sdram.sv ====
`timescale 1ns/100ps

module sdram (
  input  logic             clk,
  input  logic             reset,
  input  logic             cke,
  input  logic             cs,
  input  logic             ras,
  input  logic             cas,
  input  logic             we,
  input  sdram_pkg::addr_t a,
  input  sdram_pkg::bank_t ba,
  input  sdram_pkg::mask_t dqm,
  input  sdram_pkg::data_t dq_in,
  output sdram_pkg::data_t dq_out,
  output logic             dq_oe
);

  sdram_pkg::cmd_e     cmd;
  sdram_pkg::bank_t    cmd_bank;
  sdram_pkg::row_t     cmd_row;
  sdram_pkg::col_t     cmd_col;
  sdram_pkg::bl_code_t bl_code;
  sdram_pkg::cl_t      cl;

  logic                wr_en;
  sdram_pkg::bank_t    wr_bank;
  sdram_pkg::row_t     wr_row;
  sdram_pkg::col_t     wr_col;
  sdram_pkg::mask_t    wr_mask;
  sdram_pkg::data_t    wr_data;
  logic                rd_en;
  sdram_pkg::bank_t    rd_bank;
  sdram_pkg::row_t     rd_row;
  sdram_pkg::col_t     rd_col;
  sdram_pkg::data_t    rd_data;
  logic                rd_valid;

  sdram_cmd_decode u_decode (
    .clk      (clk),
    .reset    (reset),
    .cke      (cke),
    .cs       (cs),
    .ras      (ras),
    .cas      (cas),
    .we       (we),
    .a        (a),
    .ba       (ba),
    .cmd      (cmd),
    .cmd_bank (cmd_bank),
    .cmd_row  (cmd_row),
    .cmd_col  (cmd_col),
    .bl_code  (bl_code),
    .cl       (cl)
  );

  sdram_burst_exec u_exec (
    .clk      (clk),
    .reset    (reset),
    .cmd      (cmd),
    .cmd_bank (cmd_bank),
    .cmd_row  (cmd_row),
    .cmd_col  (cmd_col),
    .bl_code  (bl_code),
    .dq_in    (dq_in),
    .dqm      (dqm),
    .wr_en    (wr_en),
    .wr_bank  (wr_bank),
    .wr_row   (wr_row),
    .wr_col   (wr_col),
    .wr_mask  (wr_mask),
    .wr_data  (wr_data),
    .rd_en    (rd_en),
    .rd_bank  (rd_bank),
    .rd_row   (rd_row),
    .rd_col   (rd_col)
  );

  sdram_bank_array u_array (
    .clk      (clk),
    .reset    (reset),
    .wr_en    (wr_en),
    .wr_bank  (wr_bank),
    .wr_row   (wr_row),
    .wr_col   (wr_col),
    .wr_mask  (wr_mask),
    .wr_data  (wr_data),
    .rd_en    (rd_en),
    .rd_bank  (rd_bank),
    .rd_row   (rd_row),
    .rd_col   (rd_col),
    .rd_data  (rd_data),
    .rd_valid (rd_valid)
  );

  sdram_read_pipe u_pipe (
    .clk      (clk),
    .reset    (reset),
    .rd_data  (rd_data),
    .rd_valid (rd_valid),
    .cl       (cl),
    .dq_out   (dq_out),
    .dq_oe    (dq_oe)
  );

endmodule

// ==== verilog/sdram_read_pipe.sv ====
`timescale 1ns/100ps

module sdram_read_pipe (
  input  logic             clk,
  input  logic             reset,
  input  sdram_pkg::data_t rd_data,
  input  logic             rd_valid,
  input  sdram_pkg::cl_t   cl,
  output sdram_pkg::data_t dq_out,
  output logic             dq_oe
);

  sdram_pkg::data_t line_data [2];
  logic [1:0]       line_valid;
  logic             tap_late;

  // array register is the first cycle of latency, the line adds one or two more
  always_ff @(posedge clk) begin
    line_data[0] <= rd_data;
    line_data[1] <= line_data[0];
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      line_valid <= '0;
    end else begin
      line_valid <= {line_valid[0], rd_valid};
    end
  end

  assign tap_late = (cl != 3'd2); // cl 3 takes the second stage

  assign dq_out = tap_late ? line_data[1] : line_data[0];
  assign dq_oe  = tap_late ? line_valid[1] : line_valid[0];

endmodule

// ==== verilog/sdram_bank_array.sv ====
`timescale 1ns/100ps
`include "sdram_macros.svh"

module sdram_bank_array (
  input  logic             clk,
  input  logic             reset,
  input  logic             wr_en,
  input  sdram_pkg::bank_t wr_bank,
  input  sdram_pkg::row_t  wr_row,
  input  sdram_pkg::col_t  wr_col,
  input  sdram_pkg::mask_t wr_mask,
  input  sdram_pkg::data_t wr_data,
  input  logic             rd_en,
  input  sdram_pkg::bank_t rd_bank,
  input  sdram_pkg::row_t  rd_row,
  input  sdram_pkg::col_t  rd_col,
  output sdram_pkg::data_t rd_data,
  output logic             rd_valid
);

  localparam int ROWS = 1 << `SDRAM_ROW_BITS;
  localparam int COLS = 1 << `SDRAM_COL_BITS;
  localparam int HALF = `SDRAM_DATA_BITS / 2;

  sdram_pkg::data_t mem [4][ROWS][COLS];

  // byte lanes written separately, a high mask bit keeps the stored byte
  always_ff @(posedge clk) begin
    if (wr_en) begin
      if (!wr_mask[1]) begin
        mem[wr_bank][wr_row][wr_col][`SDRAM_DATA_BITS-1:HALF] <=
          wr_data[`SDRAM_DATA_BITS-1:HALF];
      end
      if (!wr_mask[0]) begin
        mem[wr_bank][wr_row][wr_col][HALF-1:0] <= wr_data[HALF-1:0];
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rd_en) begin
      rd_data <= mem[rd_bank][rd_row][rd_col];
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      rd_valid <= 1'b0;
    end else begin
      rd_valid <= rd_en; // flags the word in rd_data
    end
  end

endmodule

// ==== verilog/sdram_burst_exec.sv ====
`timescale 1ns/100ps

module sdram_burst_exec (
  input  logic                clk,
  input  logic                reset,
  input  sdram_pkg::cmd_e     cmd,
  input  sdram_pkg::bank_t    cmd_bank,
  input  sdram_pkg::row_t     cmd_row,
  input  sdram_pkg::col_t     cmd_col,
  input  sdram_pkg::bl_code_t bl_code,
  input  sdram_pkg::data_t    dq_in,
  input  sdram_pkg::mask_t    dqm,
  output logic                wr_en,
  output sdram_pkg::bank_t    wr_bank,
  output sdram_pkg::row_t     wr_row,
  output sdram_pkg::col_t     wr_col,
  output sdram_pkg::mask_t    wr_mask,
  output sdram_pkg::data_t    wr_data,
  output logic                rd_en,
  output sdram_pkg::bank_t    rd_bank,
  output sdram_pkg::row_t     rd_row,
  output sdram_pkg::col_t     rd_col
);

  sdram_pkg::burst_e state_r;
  logic [3:0]        bl_words;
  logic [3:0]        len_r;
  logic [3:0]        cnt_r;
  logic [3:0]        cnt_next;
  sdram_pkg::bank_t  bank_r;
  sdram_pkg::row_t   row_r;
  sdram_pkg::col_t   col_r;
  logic              start_rd;
  logic              start_wr;
  logic              interrupt;
  logic              burst_act;

  always_comb begin
    case (bl_code)
      3'd0:    bl_words = 4'd1;
      3'd1:    bl_words = 4'd2;
      3'd2:    bl_words = 4'd4;
      default: bl_words = 4'd8; // full page not modelled
    endcase
  end

  assign start_rd  = (cmd == sdram_pkg::cmd_read);
  assign start_wr  = (cmd == sdram_pkg::cmd_write);
  assign interrupt = start_rd || start_wr || (cmd == sdram_pkg::cmd_stop);
  assign burst_act = (state_r != sdram_pkg::burst_idle) && !interrupt;
  assign cnt_next  = cnt_r + 4'd1;

  // word 0 goes straight from the pins, later words from the burst registers
  assign wr_en   = start_wr || (burst_act && state_r == sdram_pkg::burst_write);
  assign wr_bank = start_wr ? cmd_bank : bank_r;
  assign wr_row  = start_wr ? cmd_row : row_r;
  assign wr_col  = start_wr ? cmd_col : col_r;
  assign wr_mask = dqm;
  assign wr_data = dq_in;

  assign rd_en   = start_rd || (burst_act && state_r == sdram_pkg::burst_read);
  assign rd_bank = start_rd ? cmd_bank : bank_r;
  assign rd_row  = start_rd ? cmd_row : row_r;
  assign rd_col  = start_rd ? cmd_col : col_r;

  always_ff @(posedge clk) begin
    if (reset) begin
      state_r <= sdram_pkg::burst_idle;
      cnt_r   <= '0;
      len_r   <= 4'd1;
    end else if (start_rd || start_wr) begin
      cnt_r <= 4'd1; // word 0 issued this cycle
      len_r <= bl_words;
      if (bl_words == 4'd1) begin
        state_r <= sdram_pkg::burst_idle;
      end else if (start_rd) begin
        state_r <= sdram_pkg::burst_read;
      end else begin
        state_r <= sdram_pkg::burst_write;
      end
    end else if (cmd == sdram_pkg::cmd_stop) begin
      state_r <= sdram_pkg::burst_idle; // burst terminate
    end else if (state_r != sdram_pkg::burst_idle) begin
      cnt_r <= cnt_next;
      if (cnt_next == len_r) begin
        state_r <= sdram_pkg::burst_idle;
      end
    end
  end

  // address of the next burst word, column wraps inside the row
  always_ff @(posedge clk) begin
    if (start_rd || start_wr) begin
      bank_r <= cmd_bank;
      row_r  <= cmd_row;
      col_r  <= cmd_col + 1'b1;
    end else if (burst_act) begin
      col_r <= col_r + 1'b1;
    end
  end

endmodule

// ==== verilog/sdram_cmd_decode.sv ====
`timescale 1ns/100ps
`include "sdram_macros.svh"

module sdram_cmd_decode (
  input  logic                clk,
  input  logic                reset,
  input  logic                cke,
  input  logic                cs,
  input  logic                ras,
  input  logic                cas,
  input  logic                we,
  input  sdram_pkg::addr_t    a,
  input  sdram_pkg::bank_t    ba,
  output sdram_pkg::cmd_e     cmd,
  output sdram_pkg::bank_t    cmd_bank,
  output sdram_pkg::row_t     cmd_row,
  output sdram_pkg::col_t     cmd_col,
  output sdram_pkg::bl_code_t bl_code,
  output sdram_pkg::cl_t      cl
);

  sdram_pkg::row_t open_row [4];

  always_comb begin
    cmd = sdram_pkg::cmd_nop;
    if (cke && !cs) begin
      case ({ras, cas, we})
        3'b000:  cmd = sdram_pkg::cmd_mode;
        3'b011:  cmd = sdram_pkg::cmd_active;
        3'b101:  cmd = sdram_pkg::cmd_read;
        3'b100:  cmd = sdram_pkg::cmd_write;
        3'b110:  cmd = sdram_pkg::cmd_stop;
        default: cmd = sdram_pkg::cmd_nop; // refresh, precharge and nop
      endcase
    end
  end

  assign cmd_bank = ba;
  assign cmd_row  = open_row[ba]; // row used by read and write
  assign cmd_col  = a[`SDRAM_COL_BITS-1:0];

  // mode register, only burst length and cas latency are kept
  always_ff @(posedge clk) begin
    if (reset) begin
      bl_code <= `SDRAM_RESET_BL;
      cl      <= `SDRAM_RESET_CL;
    end else if (cmd == sdram_pkg::cmd_mode) begin
      bl_code <= a[2:0];
      cl      <= (a[6:4] == 3'd2) ? 3'd2 : 3'd3; // reserved codes act as 3
    end
  end

  // one open row per bank
  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < 4; i++) begin
        open_row[i] <= '0;
      end
    end else if (cmd == sdram_pkg::cmd_active) begin
      open_row[ba] <= a[`SDRAM_ROW_BITS-1:0]; // upper row bits ignored
    end
  end

endmodule

// ==== verilog/sdram_pkg.sv ====
`include "sdram_macros.svh"

package sdram_pkg;

  typedef logic [`SDRAM_DATA_BITS-1:0]   data_t;
  typedef logic [1:0]                    mask_t; // bit 1 upper byte, bit 0 lower byte
  typedef logic [`SDRAM_BANK_BITS-1:0]   bank_t;
  typedef logic [`SDRAM_ROW_BITS-1:0]    row_t;
  typedef logic [`SDRAM_COL_BITS-1:0]    col_t;
  typedef logic [`SDRAM_ADDR_BITS-1:0]   addr_t;
  typedef logic [2:0]                    bl_code_t;
  typedef logic [2:0]                    cl_t;

  // commands after cke and cs qualification
  typedef enum logic [2:0] {
    cmd_nop,
    cmd_mode,
    cmd_active,
    cmd_read,
    cmd_write,
    cmd_stop
  } cmd_e;

  typedef enum logic [1:0] {
    burst_idle,
    burst_read,
    burst_write
  } burst_e;

endpackage

// ==== verilog/sdram_macros.svh ====
`ifndef SDRAM_MACROS_SVH
`define SDRAM_MACROS_SVH

// storage size of the model, far smaller than the real device
// row address bits above SDRAM_ROW_BITS are dropped on activate
`define SDRAM_ROW_BITS 4

// 32 columns per row, bursts wrap inside this range
`define SDRAM_COL_BITS 5

// data bus width, two byte lanes under dqm[1:0]
`define SDRAM_DATA_BITS 16

// address pin count and bank count of the device
`define SDRAM_ADDR_BITS 13
`define SDRAM_BANK_BITS 2

// mode register contents after reset
`define SDRAM_RESET_BL 3'd0 // burst length 1
`define SDRAM_RESET_CL 3'd2 // cas latency 2

`endif
